/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Base widths
    ////////////////////////////////////////////////////////////////////////////

    // Data path and address width for RV32I
    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Function codes
    ////////////////////////////////////////////////////////////////////////////

    // ALU funct3 values shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Jump selectors carried in the funct3 slot by the decoder
    localparam logic [2:0] F3_JAL  = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b011;

    // ALU operation where the iop flag picks SUB or SRA on the shared codes
    typedef enum logic [2:0] {
        ALU_ADD_SUB = F3_ADD_SUB,
        ALU_SLL     = F3_SLL,
        ALU_SLT     = F3_SLT,
        ALU_SLTU    = F3_SLTU,
        ALU_XOR     = F3_XOR,
        ALU_SRL_SRA = F3_SRL_SRA,
        ALU_OR      = F3_OR,
        ALU_AND     = F3_AND
    } alu_funct3_e;

    // Branch funct3 read as a compare recipe
    // BEQ 000, BNE 001, BLT 100, BGE 101, BLTU 110, BGEU 111
    typedef struct packed {
        logic less;          // Less-than instead of equality
        logic unsigned_cmp;  // Unsigned less-than
        logic negate;        // Invert the outcome
    } br_cond_s;

    // One funct3 word with two readings
    typedef union packed {
        alu_funct3_e alu;
        br_cond_s    branch;
    } ex_op_u;

endpackage

/* hw/ex_pipe_pkg.sv */
package ex_pipe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Decoded control word
    ////////////////////////////////////////////////////////////////////////////

    // Category flags are one-hot with exactly one set per instruction
    // iop meaning per category
    //   alu_imm / alu_reg   SRA(I) or SUB
    //   load_upper_imm      LUI when set, AUIPC when clear
    //   mem                 store when set, load when clear
    typedef struct packed {
        logic               alu_imm;
        logic               alu_reg;
        logic               cond_branch;
        logic               uncond_branch;
        logic               load_upper_imm;
        logic               mem;
        logic               iop;
        rv_isa_pkg::ex_op_u fcs_opcode;
    } ex_ctrl_s;

    ////////////////////////////////////////////////////////////////////////////
    // Stage request and response
    ////////////////////////////////////////////////////////////////////////////

    // One decoded instruction entering the stage
    // For LUI and AUIPC imm holds the raw 20-bit field in the low bits
    typedef struct packed {
        ex_ctrl_s                    ctrl;
        logic [rv_isa_pkg::XLEN-1:0] pc;
        logic [rv_isa_pkg::XLEN-1:0] rs1;
        logic [rv_isa_pkg::XLEN-1:0] rs2;
        logic [rv_isa_pkg::XLEN-1:0] imm;
    } ex_req_s;

    // Result handed to the next stage
    // rd_value is the rd write data or the memory address
    typedef struct packed {
        ex_ctrl_s                    ctrl;
        logic [rv_isa_pkg::XLEN-1:0] rd_value;
        logic [rv_isa_pkg::XLEN-1:0] pc_target;
        logic                        pc_load;
    } ex_rsp_s;

    // Control FSM states
    typedef enum logic {
        EX_WAIT,
        EX_EXECUTE
    } ex_state_e;

endpackage

/* hw/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  logic [rv_isa_pkg::XLEN-1:0] i_op_a,
    input  logic [rv_isa_pkg::XLEN-1:0] i_op_b,
    input  rv_isa_pkg::alu_funct3_e     i_op,
    input  logic                        i_invert,
    output logic [rv_isa_pkg::XLEN-1:0] o_result
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] b_eff;
    logic [XLEN-1:0] sum;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    ////////////////////////////////////////////////////////////////////////////
    // Shared adder and compares
    ////////////////////////////////////////////////////////////////////////////

    // SUB as a + ~b + 1
    assign b_eff = i_invert ? ~i_op_b : i_op_b;
    assign sum   = i_op_a + b_eff + {{(XLEN-1){1'b0}}, i_invert};

    assign lt_signed   = $signed(i_op_a) < $signed(i_op_b);
    assign lt_unsigned = i_op_a < i_op_b;

    // Only the low five bits count for RV32 shifts
    assign shamt = i_op_b[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        o_result = '0;
        case (i_op)
            ALU_ADD_SUB: o_result = sum;
            ALU_SLL:     o_result = i_op_a << shamt;
            ALU_SLT:     o_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:    o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:     o_result = i_op_a ^ i_op_b;
            ALU_SRL_SRA: begin
                // Arithmetic shift keeps the sign bit
                if (i_invert) begin
                    o_result = $signed(i_op_a) >>> shamt;
                end else begin
                    o_result = i_op_a >> shamt;
                end
            end
            ALU_OR:      o_result = i_op_a | i_op_b;
            ALU_AND:     o_result = i_op_a & i_op_b;
            default:     o_result = '0;
        endcase
    end

endmodule

/* hw/ex_branch_unit.sv */
`timescale 1ns/1ps

module ex_branch_unit (
    input  ex_pipe_pkg::ex_req_s        i_req,
    output logic                        o_pc_load,
    output logic [rv_isa_pkg::XLEN-1:0] o_pc_target,
    output logic [rv_isa_pkg::XLEN-1:0] o_link
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    br_cond_s        cond;
    logic [2:0]      funct3;
    logic            equal;
    logic            less;
    logic            taken;
    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] jalr_target;

    ////////////////////////////////////////////////////////////////////////////
    // Condition evaluation
    ////////////////////////////////////////////////////////////////////////////

    // Branch view of the union
    assign cond   = i_req.ctrl.fcs_opcode.branch;
    assign funct3 = i_req.ctrl.fcs_opcode;

    assign equal = i_req.rs1 == i_req.rs2;
    assign less  = cond.unsigned_cmp ? (i_req.rs1 < i_req.rs2)
                                     : ($signed(i_req.rs1) < $signed(i_req.rs2));

    // BNE, BGE and BGEU are the negated forms
    assign taken = (cond.less ? less : equal) ^ cond.negate;

    ////////////////////////////////////////////////////////////////////////////
    // Targets and link
    ////////////////////////////////////////////////////////////////////////////

    assign pc_plus_4   = i_req.pc + XLEN'(4);
    assign pc_plus_imm = i_req.pc + i_req.imm;
    // JALR target is always halfword aligned
    assign jalr_target = (i_req.rs1 + i_req.imm) & ~XLEN'(1);

    // Return address for JAL and JALR
    assign o_link = pc_plus_4;

    always_comb begin
        o_pc_load   = 1'b0;
        o_pc_target = pc_plus_4;
        if (i_req.ctrl.cond_branch) begin
            o_pc_load   = taken;
            o_pc_target = taken ? pc_plus_imm : pc_plus_4;
        end else if (i_req.ctrl.uncond_branch) begin
            o_pc_load = 1'b1;
            case (funct3)
                F3_JAL:  o_pc_target = pc_plus_imm;
                F3_JALR: o_pc_target = jalr_target;
                default: o_pc_target = pc_plus_4;
            endcase
        end
    end

endmodule

/* hw/ex_control.sv */
`timescale 1ns/1ps

module ex_control (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_pipeline_ready,
    input  ex_pipe_pkg::ex_req_s        i_req,
    input  logic [rv_isa_pkg::XLEN-1:0] i_alu_result,
    input  logic                        i_pc_load,
    input  logic [rv_isa_pkg::XLEN-1:0] i_pc_target,
    input  logic [rv_isa_pkg::XLEN-1:0] i_link,
    output ex_pipe_pkg::ex_req_s        o_req_q,
    output logic [rv_isa_pkg::XLEN-1:0] o_op_a,
    output logic [rv_isa_pkg::XLEN-1:0] o_op_b,
    output rv_isa_pkg::alu_funct3_e     o_alu_op,
    output logic                        o_alu_invert,
    output ex_pipe_pkg::ex_rsp_s        o_rsp,
    output logic                        o_done
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    ex_state_e       state_q;
    ex_state_e       state_d;
    ex_req_s         req_q;
    logic            capture;
    logic [XLEN-1:0] upper_imm;
    logic [XLEN-1:0] rd_value;

    ////////////////////////////////////////////////////////////////////////////
    // Wait / execute FSM
    ////////////////////////////////////////////////////////////////////////////

    // Strobe only counts while idle
    assign capture = (state_q == EX_WAIT) && i_pipeline_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            EX_WAIT:    if (capture) state_d = EX_EXECUTE;
            EX_EXECUTE: state_d = EX_WAIT;
            default:    state_d = EX_WAIT;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state_q <= EX_WAIT;
        end else begin
            state_q <= state_d;
        end
    end

    // Instruction held for the execute cycle
    always_ff @(posedge i_clk) begin
        if (capture) begin
            req_q <= i_req;
        end
    end

    assign o_req_q = req_q;

    ////////////////////////////////////////////////////////////////////////////
    // Operand steering
    ////////////////////////////////////////////////////////////////////////////

    // U-type field moved into bits 31:12
    assign upper_imm = req_q.imm << 12;

    always_comb begin
        // Default rs1 + rs2 since branches ignore the ALU
        o_op_a       = req_q.rs1;
        o_op_b       = req_q.rs2;
        o_alu_op     = ALU_ADD_SUB;
        o_alu_invert = 1'b0;
        if (req_q.ctrl.alu_reg) begin
            o_alu_op     = req_q.ctrl.fcs_opcode.alu;
            o_alu_invert = req_q.ctrl.iop;
        end else if (req_q.ctrl.alu_imm) begin
            o_op_b       = req_q.imm;
            o_alu_op     = req_q.ctrl.fcs_opcode.alu;
            o_alu_invert = req_q.ctrl.iop;
        end else if (req_q.ctrl.load_upper_imm) begin
            // LUI adds to zero and AUIPC adds to pc
            o_op_a = req_q.ctrl.iop ? '0 : req_q.pc;
            o_op_b = upper_imm;
        end else if (req_q.ctrl.mem) begin
            // Effective address
            o_op_b = req_q.imm;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response registers
    ////////////////////////////////////////////////////////////////////////////

    // Jumps write the return address and all else the ALU result
    assign rd_value = req_q.ctrl.uncond_branch ? i_link : i_alu_result;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_rsp  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= (state_q == EX_EXECUTE);
            // Held until the next instruction completes
            if (state_q == EX_EXECUTE) begin
                o_rsp.ctrl      <= req_q.ctrl;
                o_rsp.rd_value  <= rd_value;
                o_rsp.pc_target <= i_pc_target;
                o_rsp.pc_load   <= i_pc_load;
            end
        end
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_pipeline_ready,
    input  ex_pipe_pkg::ex_req_s i_req,
    output ex_pipe_pkg::ex_rsp_s o_rsp,
    output logic                 o_done
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    // Captured instruction to the branch unit
    ex_req_s         req_q;
    // ALU hookup
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    alu_funct3_e     alu_op;
    logic            alu_invert;
    logic [XLEN-1:0] alu_result;
    // Branch unit results
    logic            pc_load;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] link;

    ex_control i_ex_control (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pipeline_ready (i_pipeline_ready),
        .i_req            (i_req),
        .i_alu_result     (alu_result),
        .i_pc_load        (pc_load),
        .i_pc_target      (pc_target),
        .i_link           (link),
        .o_req_q          (req_q),
        .o_op_a           (op_a),
        .o_op_b           (op_b),
        .o_alu_op         (alu_op),
        .o_alu_invert     (alu_invert),
        .o_rsp            (o_rsp),
        .o_done           (o_done)
    );

    ex_alu i_ex_alu (
        .i_op_a   (op_a),
        .i_op_b   (op_b),
        .i_op     (alu_op),
        .i_invert (alu_invert),
        .o_result (alu_result)
    );

    ex_branch_unit i_ex_branch_unit (
        .i_req       (req_q),
        .o_pc_load   (pc_load),
        .o_pc_target (pc_target),
        .o_link      (link)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_reset
);
    // Free running clock
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset held for the first cycles and released just after an edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_reset = 1'b0;
    end

endmodule

/* sim/tb_execute_stage.sv */
`timescale 1ns/1ps

module tb_execute_stage;
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 96436;
    localparam int N_RAND       = 24;
    // Sum of the instructions issued by the six tests in order
    localparam int N_INSTR      = 2 + (N_RAND + 8) + N_RAND + 24 + 4 + 5;

    // Category selectors for building requests
    localparam int CAT_ALU_IMM = 0;
    localparam int CAT_ALU_REG = 1;
    localparam int CAT_BRANCH  = 2;
    localparam int CAT_JUMP    = 3;
    localparam int CAT_UPPER   = 4;
    localparam int CAT_MEM     = 5;

    logic    clk;
    logic    reset;
    logic    pipeline_ready;
    ex_req_s req;
    ex_rsp_s rsp;
    logic    done;

    // Outstanding expectations with the oldest first
    ex_rsp_s exp_q[$];
    string   name_q[$];
    string   test_name;
    int      errors;
    int      checks;
    int      tests_run;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_tb_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    execute_stage i_execute_stage (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_pipeline_ready (pipeline_ready),
        .i_req            (req),
        .o_rsp            (rsp),
        .o_done           (done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // RV32I integer op with alt selecting SUB or SRA
    function automatic logic [XLEN-1:0] int_op_result(logic [2:0] f3, logic alt,
                                                     logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << sh;
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // BEQ BNE BLT BGE BLTU BGEU by funct3
    function automatic logic branch_taken(logic [2:0] f3, logic [XLEN-1:0] a,
                                          logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic ex_rsp_s ref_execute(ex_req_s r);
        ex_rsp_s         e;
        logic [2:0]      f3;
        logic [XLEN-1:0] upper;
        logic [XLEN-1:0] jalr_sum;
        e           = '0;
        f3          = r.ctrl.fcs_opcode;
        upper       = {r.imm[19:0], 12'h000};
        jalr_sum    = r.rs1 + r.imm;
        e.ctrl      = r.ctrl;
        e.pc_target = r.pc + 32'd4;
        if (r.ctrl.alu_reg) begin
            e.rd_value = int_op_result(f3, r.ctrl.iop, r.rs1, r.rs2);
        end else if (r.ctrl.alu_imm) begin
            e.rd_value = int_op_result(f3, r.ctrl.iop, r.rs1, r.imm);
        end else if (r.ctrl.load_upper_imm) begin
            // LUI when iop is set, AUIPC otherwise
            e.rd_value = r.ctrl.iop ? upper : r.pc + upper;
        end else if (r.ctrl.mem) begin
            e.rd_value = r.rs1 + r.imm;
        end else if (r.ctrl.cond_branch) begin
            e.pc_load = branch_taken(f3, r.rs1, r.rs2);
            if (e.pc_load) begin
                e.pc_target = r.pc + r.imm;
            end
        end else if (r.ctrl.uncond_branch) begin
            e.pc_load   = 1'b1;
            e.rd_value  = r.pc + 32'd4;
            e.pc_target = (f3 == F3_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : r.pc + r.imm;
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic ex_req_s make_req(int cat, logic iop, logic [2:0] f3,
                                         logic [XLEN-1:0] pc, logic [XLEN-1:0] rs1,
                                         logic [XLEN-1:0] rs2, logic [XLEN-1:0] imm);
        ex_req_s r;
        r = '0;
        case (cat)
            CAT_ALU_IMM: r.ctrl.alu_imm        = 1'b1;
            CAT_ALU_REG: r.ctrl.alu_reg        = 1'b1;
            CAT_BRANCH:  r.ctrl.cond_branch    = 1'b1;
            CAT_JUMP:    r.ctrl.uncond_branch  = 1'b1;
            CAT_UPPER:   r.ctrl.load_upper_imm = 1'b1;
            default:     r.ctrl.mem            = 1'b1;
        endcase
        r.ctrl.iop            = iop;
        r.ctrl.fcs_opcode.alu = alu_funct3_e'(f3);
        r.pc                  = pc;
        r.rs1                 = rs1;
        r.rs2                 = rs2;
        r.imm                 = imm;
        return r;
    endfunction

    function automatic logic [XLEN-1:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic check_value(string label, string field,
                               logic [XLEN-1:0] want, logic [XLEN-1:0] got);
        checks++;
        assert (got === want) else begin
            $display("[ERROR] %s %s %s: expected %h, actual %h",
                     test_name, label, field, want, got);
            errors++;
        end
    endtask

    // One strobe followed by a wait for o_done and a latency check
    task automatic issue(string label, ex_req_s r);
        int cycles;
        @(posedge clk);
        #1;
        req            = r;
        pipeline_ready = 1'b1;
        exp_q.push_back(ref_execute(r));
        name_q.push_back(label);
        @(posedge clk);
        #1;
        pipeline_ready = 1'b0;
        cycles         = 1;
        while (!done && cycles < 8) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        checks++;
        assert (done) else begin
            $display("%s %s: o_done did not come within 8 cycles", test_name, label);
            errors++;
        end
        if (done) begin
            check_value(label, "latency", 32'd2, cycles);
        end
    endtask

    // Waits for the checker to finish the last response before the tally
    task automatic end_test(int err_start);
        @(negedge clk);
        #1;
        tests_run++;
        $display("%-12s %s", test_name, (errors == err_start) ? "PASS" : "FAIL");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Response checker
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare_proc
        ex_rsp_s want;
        string   label;
        forever begin
            // Sampled mid-cycle away from the edge that loads o_rsp
            @(negedge clk);
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("%s: o_done pulsed with no instruction outstanding", test_name);
                    errors++;
                end else begin
                    want  = exp_q.pop_front();
                    label = name_q.pop_front();
                    check_value(label, "ctrl", want.ctrl, rsp.ctrl);
                    check_value(label, "pc_load", want.pc_load, rsp.pc_load);
                    if (!want.ctrl.cond_branch) begin
                        check_value(label, "rd_value", want.rd_value, rsp.rd_value);
                    end
                    if (want.ctrl.cond_branch || want.ctrl.uncond_branch) begin
                        check_value(label, "pc_target", want.pc_target, rsp.pc_target);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #((N_INSTR * 4 + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        int              seed_val;
        int              err_start;
        logic [2:0]      f3;
        logic            alt;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        pipeline_ready = 1'b0;
        req            = '0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        seed_val       = $urandom(SEED);
        @(negedge reset);

        // Reset state and strobe timing
        test_name = "handshake";
        err_start = errors;
        checks++;
        assert (done == 1'b0 && rsp == '0) else begin
            $display("o_done or o_rsp, pc_load included, not cleared by reset");
            errors++;
        end
        issue("addi", make_req(CAT_ALU_IMM, 1'b0, F3_ADD_SUB, 0, 32'd100, 0, sext12(12'hFFB)));
        // Strobe left high through the execute cycle
        @(posedge clk);
        #1;
        req            = make_req(CAT_ALU_REG, 1'b0, F3_XOR, 0, 32'h0F0F_0F0F, 32'h00FF_00FF, 0);
        pipeline_ready = 1'b1;
        exp_q.push_back(ref_execute(req));
        name_q.push_back("held_xor");
        repeat (2) @(posedge clk);
        #1;
        pipeline_ready = 1'b0;
        checks++;
        assert (done) else begin
            $display("o_done not high two edges after the held strobe");
            errors++;
        end
        @(posedge clk);
        #1;
        checks++;
        assert (!done) else begin
            $display("o_done stayed high for more than one cycle");
            errors++;
        end
        // A second result here would find the queue empty
        repeat (3) @(posedge clk);
        end_test(err_start);

        // Register ALU
        test_name = "alu_reg";
        err_start = errors;
        for (int i = 0; i < N_RAND; i++) begin
            f3  = 3'($urandom_range(7, 0));
            alt = (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) ? 1'($urandom_range(1, 0)) : 1'b0;
            a   = $urandom();
            b   = $urandom();
            issue($sformatf("rand_%0d", i), make_req(CAT_ALU_REG, alt, f3, 0, a, b, 0));
        end
        issue("sub_min", make_req(CAT_ALU_REG, 1'b1, F3_ADD_SUB, 0, 32'h8000_0000, 32'd1, 0));
        issue("sub_neg", make_req(CAT_ALU_REG, 1'b1, F3_ADD_SUB, 0, 32'd0, 32'h8000_0000, 0));
        issue("sra_31", make_req(CAT_ALU_REG, 1'b1, F3_SRL_SRA, 0, 32'h8000_0000, 32'd31, 0));
        issue("sra_hi", make_req(CAT_ALU_REG, 1'b1, F3_SRL_SRA, 0, 32'hFFFF_FFF0,
                                 32'hFFFF_FFE4, 0));
        issue("slt_min", make_req(CAT_ALU_REG, 1'b0, F3_SLT, 0, 32'h8000_0000, 32'h7FFF_FFFF, 0));
        issue("sltu_min", make_req(CAT_ALU_REG, 1'b0, F3_SLTU, 0, 32'h8000_0000,
                                   32'h7FFF_FFFF, 0));
        issue("slt_m1", make_req(CAT_ALU_REG, 1'b0, F3_SLT, 0, 32'hFFFF_FFFF, 32'd0, 0));
        issue("sltu_m1", make_req(CAT_ALU_REG, 1'b0, F3_SLTU, 0, 32'hFFFF_FFFF, 32'd0, 0));
        end_test(err_start);

        // Immediate ALU with the shift amount in imm[4:0]
        test_name = "alu_imm";
        err_start = errors;
        for (int i = 0; i < N_RAND; i++) begin
            f3  = 3'($urandom_range(7, 0));
            alt = 1'b0;
            a   = $urandom();
            imm = sext12(12'($urandom()));
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                // SRAI carries imm[10] set
                alt = (f3 == F3_SRL_SRA) ? 1'($urandom_range(1, 0)) : 1'b0;
                imm = {21'd0, alt, 5'd0, 5'($urandom())};
            end
            issue($sformatf("rand_%0d", i), make_req(CAT_ALU_IMM, alt, f3, 0, a, 0, imm));
        end
        end_test(err_start);

        // Conditional branches against equal, mixed sign and greater operands
        test_name = "branch";
        err_start = errors;
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? 3'(c) : 3'(c + 2);
            for (int k = 0; k < 4; k++) begin
                case (k)
                    0: begin
                        a = 32'd5;
                        b = 32'd5;
                    end
                    1: begin
                        a = 32'hFFFF_FFFD;
                        b = 32'd7;
                    end
                    2: begin
                        a = 32'd9;
                        b = 32'd2;
                    end
                    default: begin
                        a = 32'd1;
                        b = 32'hFFFF_FFFF;
                    end
                endcase
                pc  = $urandom() & 32'hFFFF_FFFC;
                imm = {{19{1'b0}}, 12'($urandom()), 1'b0};
                imm = imm[12] ? imm | 32'hFFFF_E000 : imm;
                issue($sformatf("f3_%0d_pair_%0d", f3, k), make_req(CAT_BRANCH, 1'b0, f3,
                                                                  pc, a, b, imm));
            end
        end
        end_test(err_start);

        // JAL and JALR
        test_name = "jump";
        err_start = errors;
        issue("jal_fwd", make_req(CAT_JUMP, 1'b0, F3_JAL, 32'h0000_1000, $urandom(), 0, 32'h40));
        issue("jal_back", make_req(CAT_JUMP, 1'b0, F3_JAL, 32'h0000_2000, 0, 0, 32'hFFFF_FF00));
        issue("jalr_odd", make_req(CAT_JUMP, 1'b0, F3_JALR, 32'h0000_3000, 32'h0000_1001, 0,
                                   32'h10));
        issue("jalr_neg", make_req(CAT_JUMP, 1'b0, F3_JALR, 32'h0000_4000, 32'h2000_0003, 0,
                                   32'hFFFF_FFF0));
        end_test(err_start);

        // LUI, AUIPC and address generation
        test_name = "upper_mem";
        err_start = errors;
        issue("lui", make_req(CAT_UPPER, 1'b1, 3'b000, 32'h0000_8000, $urandom(), 0,
                              32'h000A_BCDE));
        issue("auipc", make_req(CAT_UPPER, 1'b0, 3'b000, 32'h0000_8004, 0, 0, 32'h000F_FFFF));
        issue("load", make_req(CAT_MEM, 1'b0, 3'b010, 0, 32'h1000_0000, 0, sext12(12'h7FC)));
        issue("store", make_req(CAT_MEM, 1'b1, 3'b010, 0, 32'h1000_0000, $urandom(),
                                sext12(12'h123)));
        issue("load_neg", make_req(CAT_MEM, 1'b0, 3'b000, 0, 32'h0000_0010, 0,
                                   sext12(12'h800)));
        end_test(err_start);

        @(posedge clk);
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("%0d expected responses never arrived", exp_q.size());
            errors++;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* flist.f */
hw/rv_isa_pkg.sv
hw/ex_pipe_pkg.sv
hw/ex_alu.sv
hw/ex_branch_unit.sv
hw/ex_control.sv
hw/execute_stage.sv
sim/tb_clock_gen.sv
sim/tb_execute_stage.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  # Packages first, then the RTL
  - files:
      - hw/rv_isa_pkg.sv
      - hw/ex_pipe_pkg.sv
      - hw/ex_alu.sv
      - hw/ex_branch_unit.sv
      - hw/ex_control.sv
      - hw/execute_stage.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_execute_stage.sv
